/* tb/st_bus_tests.txt */
# op a b c d e f, all hex. 1 mem: cfg addr rw oe wr dtack. 2 io: cfg addr sel_bit lane_mask
# 3 arb: cfg addr br_mask hs cpu_owner vid_owner. 4 lines: vs hs mfp ipl. 5 ack: level vector ipl
# 6 berr: cfg addr br_mask berr expected. owners 0 cpu 1 dma 2 blitter 3 video 4 sound
4 1 0 0 3 0 0
4 1 1 0 3 0 0
4 1 1 1 1 0 0
4 1 1 0 3 0 0
5 4 1c 5 0 0 0
5 2 1a 7 0 0 0
4 0 0 0 7 0 0
1 00 000000 1 1 0 1
1 00 000000 0 0 0 0
1 00 001000 0 0 1 1
1 00 001006 1 1 0 1
1 00 400000 1 0 0 0
1 80 400002 1 1 0 1
1 a0 c00004 1 1 0 1
1 00 e80000 1 0 0 0
1 18 e80000 0 0 1 1
1 00 e00000 1 1 0 1
1 00 e00000 0 0 0 0
1 00 fc0000 1 1 0 1
1 00 fa0000 1 1 0 1
1 00 fb0000 1 1 0 1
1 02 fb0000 1 0 0 1
2 00 ff8200 c ffff 0 0
2 00 ff8000 b 00ff 0 0
2 00 ff8604 2 ffff 0 0
2 00 ff8800 3 ff00 0 0
2 10 ff8900 7 ffff 0 0
2 04 ff8a00 4 ffff 0 0
2 10 ff9200 8 ffff 0 0
2 00 fffa00 6 00ff 0 0
2 00 fffc00 5 ff00 0 0
2 08 ff8e20 a 00ff 0 0
2 08 ff8e00 9 ffff 0 0
2 02 fb0000 1 ff00 0 0
3 00 002000 0 0 0 3
3 00 002002 1 0 1 3
3 00 002004 2 0 2 3
3 00 002006 3 0 1 3
3 10 002008 0 1 0 4
3 00 00200a 0 1 0 3
3 10 00200c 2 1 2 4
6 00 ff8400 0 1 0 0
6 00 ff8400 1 0 0 0

/* sources.f */
hdl/st_bus_pkg.sv
hdl/st_addr_decode.sv
hdl/st_bus_slots.sv
hdl/st_bus_timeout.sv
hdl/st_irq_ctrl.sv
hdl/st_bus_glue.sv
tb/tb_st_bus_glue.sv

/* tb/tb_st_bus_glue.sv */
/*
 * ST bus glue testbench
 * reads test records, drives the DUT one bus slot at a time and checks
 * decode, arbitration, interrupts and the bus error watchdog
 */
`timescale 1ns/10ps

module tb_st_bus_glue;
	import st_bus_pkg::*;

	// marker addresses so the owner of a slot shows on ram.addr
	localparam waddr_t VID_MARK  = 23'h012340;
	localparam waddr_t SND_MARK  = 23'h023450;
	localparam waddr_t DMA_MARK  = 23'h034560;
	localparam waddr_t BLIT_MARK = 23'h045670;
	// idle cpu sits on a ram word outside the reset vectors
	localparam waddr_t IDLE_ADR  = 23'h000008;

	logic        clk_8;
	logic        pll_locked;
	st_cfg_t     cfg;
	cpu_bus_t    cpu;
	logic        clr_berr;
	master_req_t dma_master;
	master_req_t blit_master;
	waddr_t      vid_addr;
	waddr_t      snd_addr;
	logic        vid_read;
	logic        snd_read;
	logic        st_hs;
	logic        st_vs;
	logic        mfp_irq;
	io_rdata_t   io_rdata;
	line_t       ram_line;
	ram_req_t    ram;
	io_sel_t     io_sel;
	word_t       cpu_rdata;
	logic        dtack;
	logic        berr;
	logic [2:0]  ipl;

	logic [15:0] lfsr_state = 16'd41;

	st_bus_glue i_dut (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cfg         (cfg),
		.cpu         (cpu),
		.clr_berr    (clr_berr),
		.dma_master  (dma_master),
		.blit_master (blit_master),
		.vid_addr    (vid_addr),
		.snd_addr    (snd_addr),
		.vid_read    (vid_read),
		.snd_read    (snd_read),
		.st_hs       (st_hs),
		.st_vs       (st_vs),
		.mfp_irq     (mfp_irq),
		.io_rdata    (io_rdata),
		.ram_line    (ram_line),
		.ram         (ram),
		.io_sel      (io_sel),
		.cpu_rdata   (cpu_rdata),
		.dtack       (dtack),
		.berr        (berr),
		.ipl         (ipl)
	);

	initial clk_8 = 1'b0;
	always #4 clk_8 = ~clk_8;

	// fibonacci lfsr with taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], lfsr_bit()};
		return v;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("FAILED at %0t ns: %s", $time, msg);
			$display("tests failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic abort(input string msg);
		$display("error: %s", msg);
		$display("tests failed");
		$fatal(1, "stopping");
	endtask

	// new peripheral words and a new sdram line per record
	task automatic fill_random_data;
		for (int k = 0; k < 13; k++)
			io_rdata[k*16 +: 16] = word_t'(rand_bits(16));
		ram_line = rand_bits(64);
	endtask

	task automatic next_cycle;
		@(posedge clk_8);
		#1;
	endtask

	task automatic cpu_idle;
		cpu.adr  = IDLE_ADR;
		cpu.fc   = 3'b101;
		cpu.as   = 1'b0;
		cpu.rw   = 1'b1;
		cpu.uds  = 1'b1;
		cpu.lds  = 1'b1;
		cpu.dout = '0;
	endtask

	task automatic cpu_access(input logic [23:0] byte_adr, input logic rw,
		input logic [2:0] fc);
		cpu.adr  = byte_adr[23:1];
		cpu.fc   = fc;
		cpu.as   = 1'b1;
		cpu.rw   = rw;
		cpu.uds  = 1'b1;
		cpu.lds  = 1'b1;
		cpu.dout = 16'h5a5a;
	endtask

	// bit 0 requests the dma master, bit 1 the blitter
	task automatic set_masters(input logic [1:0] mask);
		dma_master.br  = mask[0];
		blit_master.br = mask[1];
	endtask

	// find the video slot by its known read and return in slot 3
	task automatic align_video_slot;
		int  n;
		logic found;
		found = 1'b0;
		n = 0;
		next_cycle();
		cpu_idle();
		set_masters(2'b00);
		vid_read = 1'b1;
		while (!found && n < 8) begin
			next_cycle();
			#4;
			// video or sound owns it, depending on st_hs
			found = ram.oe && (ram.addr == VID_MARK || ram.addr == SND_MARK);
			n++;
		end
		if (!found)
			abort("no video slot seen while aligning to the bus slots");
		repeat (3) next_cycle();
	endtask

	function automatic waddr_t owner_addr(input int code, input logic [23:0] byte_adr);
		case (code)
			1: return DMA_MARK;
			2: return BLIT_MARK;
			3: return VID_MARK;
			4: return SND_MARK;
			default: return byte_adr[23:1];
		endcase
	endfunction

	task automatic decode_memory(input logic [7:0] c, input logic [23:0] adr, input logic rw,
		input logic e_oe, input logic e_wr, input logic e_dtack);
		word_t exp_word;
		align_video_slot();
		next_cycle();
		cfg = st_cfg_t'(c);
		cpu_access(adr, rw, 3'b101);
		// writes go out on the upper byte only
		if (!rw)
			cpu.lds = 1'b0;
		next_cycle();
		#4;
		check(ram.oe === e_oe && ram.wr === e_wr && dtack === e_dtack,
			$sformatf("mem %h rw %0d cfg %h: oe wr dtack %b%b%b, expected %b%b%b",
			adr, rw, c, ram.oe, ram.wr, dtack, e_oe, e_wr, e_dtack));
		if (e_wr)
			check(ram.din === 16'h5a5a && ram.uds === 1'b1 && ram.lds === 1'b0,
				$sformatf("mem %h: write %h strobes %b%b, expected 5a5a and 10", adr,
				ram.din, ram.uds, ram.lds));
		// word n of the line where n is the low two word address bits
		exp_word = word_t'(ram_line >> (16 * adr[2:1]));
		if (e_oe)
			check(cpu_rdata === exp_word, $sformatf("mem %h: read %h, expected %h",
				adr, cpu_rdata, exp_word));
		next_cycle();
		cpu_idle();
	endtask

	task automatic read_io_register(input logic [7:0] c, input logic [23:0] adr,
		input int sel_bit, input logic [15:0] lane_mask);
		io_sel_t exp_sel;
		word_t   exp_data;
		exp_sel  = io_sel_t'(13'd1 << sel_bit);
		exp_data = io_rdata[sel_bit*16 +: 16] & lane_mask;
		align_video_slot();
		next_cycle();
		cfg = st_cfg_t'(c);
		cpu_access(adr, 1'b1, 3'b101);
		next_cycle();
		#4;
		check(io_sel === exp_sel, $sformatf("io %h cfg %h: select %b, expected %b",
			adr, c, io_sel, exp_sel));
		check(cpu_rdata === exp_data, $sformatf("io %h: data %h, expected %h",
			adr, cpu_rdata, exp_data));
		check(dtack === 1'b1, $sformatf("io %h: no dtack", adr));
		next_cycle();
		cpu_idle();
	endtask

	task automatic arbitrate_masters(input logic [7:0] c, input logic [23:0] adr,
		input logic [1:0] mask, input logic hs, input int cpu_owner, input int vid_owner);
		align_video_slot();
		next_cycle();
		cfg   = st_cfg_t'(c);
		st_hs = hs;
		set_masters(mask);
		// a pending cpu write must not reach ram in the video slot
		cpu_access(adr, 1'b0, 3'b101);
		#4;
		check(ram.addr === owner_addr(vid_owner, adr) && ram.wr === 1'b0,
			$sformatf("video slot hs %0d cfg %h: addr %h wr %b", hs, c, ram.addr, ram.wr));
		next_cycle();
		cpu.rw = 1'b1;
		#4;
		check(ram.addr === owner_addr(cpu_owner, adr) && ram.oe === 1'b1,
			$sformatf("cpu slot br %b: addr %h, expected owner %0d", mask, ram.addr,
			cpu_owner));
		check(dtack === (mask == 2'b00), $sformatf("cpu slot br %b: dtack %b", mask, dtack));
		next_cycle();
		set_masters(2'b00);
		cpu_idle();
	endtask

	task automatic wait_ipl(input logic [2:0] exp_ipl, input string what);
		int n;
		n = 0;
		#4;
		while (ipl !== exp_ipl && n < 4) begin
			next_cycle();
			#4;
			n++;
		end
		check(ipl === exp_ipl, $sformatf("%s: ipl %b, expected %b", what, ipl, exp_ipl));
	endtask

	task automatic set_irq_lines(input logic vs, input logic hs, input logic mfp,
		input logic [2:0] exp_ipl);
		next_cycle();
		st_vs   = vs;
		st_hs   = hs;
		mfp_irq = mfp;
		wait_ipl(exp_ipl, $sformatf("lines vs %0d hs %0d mfp %0d", vs, hs, mfp));
	endtask

	task automatic acknowledge_level(input logic [2:0] level, input logic [7:0] vec,
		input logic [2:0] exp_ipl);
		align_video_slot();
		next_cycle();
		cpu_access({20'hfffff, level, 1'b1}, 1'b1, 3'b111);
		next_cycle();
		#4;
		check(dtack === 1'b1 && cpu_rdata === {8'h00, vec},
			$sformatf("ack level %0d: dtack %b vector %h, expected %h", level, dtack,
			cpu_rdata, vec));
		next_cycle();
		cpu_idle();
		wait_ipl(exp_ipl, $sformatf("after ack level %0d", level));
	endtask

	task automatic watch_bus_error(input logic [7:0] c, input logic [23:0] adr,
		input logic [1:0] mask, input logic exp_berr);
		int n;
		align_video_slot();
		next_cycle();
		cfg = st_cfg_t'(c);
		set_masters(mask);
		cpu_access(adr, 1'b1, 3'b101);
		n = 0;
		if (exp_berr) begin
			#4;
			while (!berr && n < 80) begin
				next_cycle();
				#4;
				n++;
			end
			if (!berr)
				abort($sformatf("no bus error within 80 cycles for %h", adr));
			next_cycle();
			cpu_idle();
			clr_berr = 1'b1;
			next_cycle();
			clr_berr = 1'b0;
			#4;
			check(berr === 1'b0, "bus error still set after clear");
		end else begin
			// a held bus request must keep the watchdog quiet
			repeat (80) begin
				next_cycle();
				#4;
				check(berr === 1'b0, $sformatf("bus error with br %b held", mask));
			end
			next_cycle();
			set_masters(2'b00);
			cpu_idle();
		end
	endtask

	initial begin
		int          fd;
		string       line;
		int          cnt;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] f;

		pll_locked = 1'b0;
		cfg        = '0;
		cpu_idle();
		clr_berr    = 1'b0;
		dma_master  = '{br: 1'b0, addr: DMA_MARK, read: 1'b1, write: 1'b0, dout: 16'h1111};
		blit_master = '{br: 1'b0, addr: BLIT_MARK, read: 1'b1, write: 1'b0, dout: 16'h2222};
		vid_addr = VID_MARK;
		snd_addr = SND_MARK;
		vid_read = 1'b0;
		snd_read = 1'b0;
		st_hs    = 1'b0;
		st_vs    = 1'b0;
		mfp_irq  = 1'b0;
		fill_random_data();

		repeat (8) begin
			next_cycle();
			#4;
			check(ipl === IPL_NONE && berr === 1'b0 && dtack === 1'b0 &&
				ram.oe === 1'b0 && ram.wr === 1'b0, "outputs not idle during reset");
		end
		next_cycle();
		pll_locked = 1'b1;
		vid_read   = 1'b1;
		snd_read   = 1'b1;
		#4;
		check(ipl === IPL_NONE && berr === 1'b0 && dtack === 1'b0,
			"outputs not idle on reset release");

		fd = $fopen("tb/st_bus_tests.txt", "r");
		if (fd == 0)
			abort("cannot open tb/st_bus_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == 8'h23)
				continue;
			cnt = $sscanf(line, "%h %h %h %h %h %h %h", op, a, b, c, d, e, f);
			if (cnt != 7)
				abort($sformatf("malformed test record: %s", line));
			next_cycle();
			fill_random_data();
			case (op)
				1: decode_memory(a[7:0], b[23:0], c[0], d[0], e[0], f[0]);
				2: read_io_register(a[7:0], b[23:0], c, d[15:0]);
				3: arbitrate_masters(a[7:0], b[23:0], c[1:0], d[0], e, f);
				4: set_irq_lines(a[0], b[0], c[0], d[2:0]);
				5: acknowledge_level(a[2:0], b[7:0], c[2:0]);
				6: watch_bus_error(a[7:0], b[23:0], c[1:0], d[0]);
				default: abort($sformatf("unknown opcode %0h", op));
			endcase
		end
		$fclose(fd);

		$display("all tests passed");
		$finish;
	end

endmodule

/* hdl/st_bus_glue.sv */
/*
 * ST bus glue top level
 * address decode, bus slots, bus error watchdog and interrupt control
 */
`timescale 1ns/10ps

module st_bus_glue (
	input  logic                    clk_8,
	input  logic                    pll_locked,
	input  st_bus_pkg::st_cfg_t     cfg,
	input  st_bus_pkg::cpu_bus_t    cpu,
	input  logic                    clr_berr,
	input  st_bus_pkg::master_req_t dma_master,
	input  st_bus_pkg::master_req_t blit_master,
	input  st_bus_pkg::waddr_t      vid_addr,
	input  st_bus_pkg::waddr_t      snd_addr,
	input  logic                    vid_read,
	input  logic                    snd_read,
	input  logic                    st_hs,
	input  logic                    st_vs,
	input  logic                    mfp_irq,
	input  st_bus_pkg::io_rdata_t   io_rdata,
	input  st_bus_pkg::line_t       ram_line,
	output st_bus_pkg::ram_req_t    ram,
	output st_bus_pkg::io_sel_t     io_sel,
	output st_bus_pkg::word_t       cpu_rdata,
	output logic                    dtack,
	output logic                    berr,
	output logic [2:0]              ipl
);
	import st_bus_pkg::*;

	logic       cpu_cycle;
	logic       br;
	word_t      ram_word;
	logic       cpu2mem;
	logic       cpu2ram;
	logic [7:0] auto_vector;

	st_addr_decode i_addr_decode (
		.cfg         (cfg),
		.cpu         (cpu),
		.cpu_cycle   (cpu_cycle),
		.br          (br),
		.ram_word    (ram_word),
		.io_rdata    (io_rdata),
		.auto_vector (auto_vector),
		.cpu2mem     (cpu2mem),
		.cpu2ram     (cpu2ram),
		.io_sel      (io_sel),
		.dtack       (dtack),
		.cpu_rdata   (cpu_rdata)
	);

	// slot number and video slot flag only matter inside the sequencer
	st_bus_slots i_bus_slots (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cfg         (cfg),
		.cpu         (cpu),
		.cpu2mem     (cpu2mem),
		.cpu2ram     (cpu2ram),
		.dma_master  (dma_master),
		.blit_master (blit_master),
		.vid_addr    (vid_addr),
		.snd_addr    (snd_addr),
		.vid_read    (vid_read),
		.snd_read    (snd_read),
		.st_hs       (st_hs),
		.ram_line    (ram_line),
		.bus_cycle   (),
		.video_cycle (),
		.cpu_cycle   (cpu_cycle),
		.br          (br),
		.ram         (ram),
		.ram_word    (ram_word)
	);

	st_bus_timeout i_bus_timeout (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.cpu_cycle  (cpu_cycle),
		.dtack      (dtack),
		.br         (br),
		.cpu2mem    (cpu2mem),
		.clr_berr   (clr_berr),
		.berr       (berr)
	);

	st_irq_ctrl i_irq_ctrl (
		.clk_8       (clk_8),
		.pll_locked  (pll_locked),
		.cpu         (cpu),
		.cpu_cycle   (cpu_cycle),
		.st_hs       (st_hs),
		.st_vs       (st_vs),
		.mfp_irq     (mfp_irq),
		.ipl         (ipl),
		.auto_vector (auto_vector)
	);

endmodule

/* hdl/st_irq_ctrl.sv */
/*
 * ST interrupt control
 * vbi and hbi edge capture, ipl priority encoder and the vectors
 * for the blank interrupts during acknowledge
 */
`timescale 1ns/10ps

module st_irq_ctrl (
	input  logic                 clk_8,
	input  logic                 pll_locked,
	input  st_bus_pkg::cpu_bus_t cpu,
	input  logic                 cpu_cycle,
	input  logic                 st_hs,
	input  logic                 st_vs,
	input  logic                 mfp_irq,
	output logic [2:0]           ipl,
	output logic [7:0]           auto_vector
);
	import st_bus_pkg::*;

	// bit 1 is vbi (level 4), bit 0 is hbi (level 2)
	logic [1:0] blank_d;
	logic [1:0] blank_d2;
	logic [1:0] pending;
	logic [1:0] ack;
	logic       iack_cyc;

	assign iack_cyc = cpu_cycle && cpu.as && (cpu.fc == FC_IACK);
	// acknowledged level shows on address bits 3..1
	assign ack = {iack_cyc && (cpu.adr[2:0] == IACK_VBI),
		iack_cyc && (cpu.adr[2:0] == IACK_HBI)};

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			blank_d  <= 2'b00;
			blank_d2 <= 2'b00;
			pending  <= 2'b00;
			ipl      <= IPL_NONE;
		end else begin
			blank_d  <= {st_vs, st_hs};
			blank_d2 <= blank_d;
			// rising edge sets, acknowledge wins over a new edge
			pending  <= (pending | (blank_d & ~blank_d2)) & ~ack;

			// mfp (6) over vbi (4) over hbi (2)
			if (mfp_irq)
				ipl <= IPL_MFP;
			else if (pending[1])
				ipl <= IPL_VBI;
			else if (pending[0])
				ipl <= IPL_HBI;
			else
				ipl <= IPL_NONE;
		end
	end

	// blank interrupts are autovectored on a real ST, the vector is supplied here
	always_comb begin
		if (ack[1])
			auto_vector = VEC_VBI;
		else if (ack[0])
			auto_vector = VEC_HBI;
		else
			auto_vector = 8'h00;
	end

endmodule

/* hdl/st_bus_timeout.sv */
/*
 * missing dtack watchdog
 * raises the CPU bus error after too many CPU slots without an answer
 */
`timescale 1ns/10ps

module st_bus_timeout (
	input  logic clk_8,
	input  logic pll_locked,
	input  logic cpu_cycle,
	input  logic dtack,
	input  logic br,
	input  logic cpu2mem,
	input  logic clr_berr,
	output logic berr
);
	import st_bus_pkg::*;

	logic       bus_ok_q;
	logic       cpu_cycle_q;
	logic [3:0] dtack_timeout;

	// sample the slot state, the counter acts on it one cycle later
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			bus_ok_q    <= 1'b0;
			cpu_cycle_q <= 1'b0;
		end else begin
			// memory access or another master never counts as missing dtack
			bus_ok_q    <= dtack || br || cpu2mem;
			cpu_cycle_q <= cpu_cycle;
		end
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			dtack_timeout <= 4'd0;
		end else if (clr_berr) begin
			dtack_timeout <= 4'd0;
		end else if (cpu_cycle_q && (dtack_timeout != BERR_LIMIT)) begin
			// holds at the limit until the cpu clears it
			if (bus_ok_q)
				dtack_timeout <= 4'd0;
			else
				dtack_timeout <= dtack_timeout + 4'd1;
		end
	end

	assign berr = (dtack_timeout == BERR_LIMIT);

endmodule

/* hdl/st_bus_slots.sv */
/*
 * ST bus slot sequencer
 * four slot counter, RAM ownership per slot and the CPU word
 * taken out of the 64 bit SDRAM line
 */
`timescale 1ns/10ps

module st_bus_slots (
	input  logic                    clk_8,
	input  logic                    pll_locked,
	input  st_bus_pkg::st_cfg_t     cfg,
	input  st_bus_pkg::cpu_bus_t    cpu,
	input  logic                    cpu2mem,
	input  logic                    cpu2ram,
	input  st_bus_pkg::master_req_t dma_master,
	input  st_bus_pkg::master_req_t blit_master,
	input  st_bus_pkg::waddr_t      vid_addr,
	input  st_bus_pkg::waddr_t      snd_addr,
	input  logic                    vid_read,
	input  logic                    snd_read,
	input  logic                    st_hs,
	input  st_bus_pkg::line_t       ram_line,
	output logic [1:0]              bus_cycle,
	output logic                    video_cycle,
	output logic                    cpu_cycle,
	output logic                    br,
	output st_bus_pkg::ram_req_t    ram,
	output st_bus_pkg::word_t       ram_word
);
	import st_bus_pkg::*;

	logic        second_cpu_slot;
	logic        snd_slot;
	master_req_t owner;
	waddr_t      cpu_slot_addr;
	logic        cpu_slot_oe;
	logic        cpu_slot_wr;

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			bus_cycle <= 2'd0;
		else
			bus_cycle <= bus_cycle + 2'd1;
	end

	// mega ste at 16MHz and steroids get slot 3 as well
	assign second_cpu_slot = (cfg.mste && cfg.enable_16mhz) || (cfg.ste && cfg.mste);
	assign video_cycle = (bus_cycle == 2'd0);
	assign cpu_cycle   = (bus_cycle == 2'd1) || (second_cpu_slot && (bus_cycle == 2'd3));

	// ste dma sound borrows the video slot during hsync
	assign snd_slot = st_hs && cfg.ste;

	// dma goes before the blitter, either one halts the cpu
	assign br    = dma_master.br || blit_master.br;
	assign owner = dma_master.br ? dma_master : blit_master;

	assign cpu_slot_addr = br ? owner.addr : cpu.adr;
	assign cpu_slot_oe   = br ? owner.read : (cpu_cycle && cpu.as && cpu.rw && cpu2mem);
	// cpu writes reach ram only, never rom
	assign cpu_slot_wr   = br ? owner.write : (cpu_cycle && cpu.as && !cpu.rw && cpu2ram);

	always_comb begin
		ram.addr = video_cycle ? (snd_slot ? snd_addr : vid_addr) : cpu_slot_addr;
		ram.oe   = 1'b0;
		ram.wr   = 1'b0;
		if (video_cycle) begin
			// video slot is read only
			ram.oe = snd_slot ? snd_read : vid_read;
		end else if (cpu_cycle) begin
			ram.oe = cpu_slot_oe;
			ram.wr = cpu_slot_wr;
		end
		// full words for video and masters, cpu brings its own strobes
		ram.uds = video_cycle || br || cpu.uds;
		ram.lds = video_cycle || br || cpu.lds;
		ram.din = br ? owner.dout : cpu.dout;
	end

	// video and sound take the whole line, the cpu slot picks one word
	assign ram_word = ram_line[{cpu_slot_addr[1:0], 4'd0} +: WORD_W];

endmodule

/* hdl/st_addr_decode.sv */
/*
 * ST address decoder
 * memory map and io register map, read data return to the CPU and dtack
 */
`timescale 1ns/10ps

module st_addr_decode (
	input  st_bus_pkg::st_cfg_t   cfg,
	input  st_bus_pkg::cpu_bus_t  cpu,
	input  logic                  cpu_cycle,
	input  logic                  br,
	input  st_bus_pkg::word_t     ram_word,
	input  st_bus_pkg::io_rdata_t io_rdata,
	input  logic [7:0]            auto_vector,
	output logic                  cpu2mem,
	output logic                  cpu2ram,
	output st_bus_pkg::io_sel_t   io_sel,
	output logic                  dtack,
	output st_bus_pkg::word_t     cpu_rdata
);
	import st_bus_pkg::*;

	logic        steroids;
	logic [7:0]  page;
	logic [15:0] io_off;
	logic        cpu2lowrom;
	logic        cpu2tos256k;
	logic        cpu2tos192k;
	logic        cpu2cart;
	logic        cpu2io;
	logic        cpu2iack;
	logic        io_acc;
	logic        auto_iack;
	logic [7:0]  hi_lane;
	logic [7:0]  lo_lane;
	word_t       io_word;

	// true when the io offset falls into the 2**span byte window at base
	function automatic logic io_hit(input logic [15:0] off, input logic [15:0] base,
		input int unsigned span);
		io_hit = (off >> span) == (base >> span);
	endfunction

	assign steroids = cfg.ste && cfg.mste;
	// adr is a word address, so adr[22:15] is byte address 23..16
	assign page   = cpu.adr[22:15];
	assign io_off = {cpu.adr[14:0], 1'b0};

	// first 8 bytes mirror the rom (reset vectors)
	assign cpu2lowrom = (cpu.adr[22:2] == '0);

	// 4M always, 8M and 14M by size, 512K at $e80000 for steroids
	assign cpu2ram = !cpu2lowrom && (
		(cpu.adr[22:21] == 2'b00) ||
		(((cfg.mem_size == MEM_8M) || (cfg.mem_size == MEM_14M)) &&
			(cpu.adr[22:21] == 2'b01)) ||
		((cfg.mem_size == MEM_14M) &&
			((cpu.adr[22:21] == 2'b10) || (cpu.adr[22:20] == 3'b110))) ||
		(steroids && (cpu.adr[22:18] == STEROIDS_AREA)));

	// tos 256k at $e00000, tos 192k at $fc0000
	assign cpu2tos256k = (cpu.adr[22:17] == TOS256_AREA);
	assign cpu2tos192k = (cpu.adr[22:16] == TOS192_LO) || (page == TOS192_HI);

	// $fb belongs to the dongle when one is fitted
	assign cpu2cart = (page == CART_PAGE) ||
		((page == DONGLE_PAGE) && !cfg.dongle_present);

	// ram is read/write, any rom area is read only
	assign cpu2mem = cpu2ram ||
		(cpu.rw && (cpu2lowrom || cpu2tos192k || cpu2tos256k || cpu2cart));

	assign cpu2io   = (page == IO_PAGE);
	assign cpu2iack = (cpu.fc == FC_IACK);
	assign io_acc   = cpu_cycle && cpu2io && cpu.as;

	// irq ctrl only supplies a vector during a vbi or hbi acknowledge
	assign auto_iack = |auto_vector;

	always_comb begin
		io_sel.mmu       = io_acc && io_hit(io_off, IO_MMU, 1);
		io_sel.vreg      = io_acc && io_hit(io_off, IO_VREG, 7);
		io_sel.dma       = io_acc && io_hit(io_off, IO_DMA, 4);
		io_sel.psg       = io_acc && io_hit(io_off, IO_PSG, 8);
		io_sel.mfp       = io_acc && io_hit(io_off, IO_MFP, 6);
		io_sel.acia      = io_acc && io_hit(io_off, IO_ACIA, 8);
		// ste always carries a blitter
		io_sel.blitter   = (cfg.blitter_en || cfg.ste) && io_acc &&
			io_hit(io_off, IO_BLITTER, 8);
		io_sel.ste_joy   = cfg.ste && io_acc && io_hit(io_off, IO_STE_JOY, 6);
		io_sel.ste_snd   = cfg.ste && io_acc && io_hit(io_off, IO_STE_SND, 6);
		// mega ste cache and vme control, absent in steroids mode
		io_sel.mste_ctrl = !steroids && cfg.mste && io_acc &&
			io_hit(io_off, IO_MSTE_CTRL, 1);
		io_sel.vme       = !steroids && cfg.mste && io_acc && io_hit(io_off, IO_VME, 4);
		// dongle is read only and spans the whole $fb page
		io_sel.dongle    = cfg.dongle_present && cpu_cycle && cpu.as && cpu.rw &&
			(page == DONGLE_PAGE);
		// level 6 acknowledge fetches the vector from the mfp
		io_sel.mfp_iack  = cpu_cycle && cpu2iack && cpu.as && (cpu.adr[2:0] == IACK_MFP);
	end

	// gather the selected device's data, byte devices on their own lane
	always_comb begin
		hi_lane = ({8{io_sel.acia}}   & io_rdata.acia.lanes.hi) |
			({8{io_sel.psg}}          & io_rdata.psg.lanes.hi) |
			({8{io_sel.dongle}}       & io_rdata.dongle.lanes.hi);
		lo_lane = ({8{io_sel.mmu}}    & io_rdata.mmu.lanes.lo) |
			({8{io_sel.mfp}}          & io_rdata.mfp.lanes.lo) |
			({8{io_sel.mste_ctrl}}    & io_rdata.mste_ctrl.lanes.lo) |
			({8{io_sel.mfp_iack}}     & io_rdata.mfp_iack.lanes.lo) |
			auto_vector;
		io_word = ({WORD_W{io_sel.vreg}} & io_rdata.vreg.word) |
			({WORD_W{io_sel.dma}}        & io_rdata.dma.word) |
			({WORD_W{io_sel.blitter}}    & io_rdata.blitter.word) |
			({WORD_W{io_sel.ste_joy}}    & io_rdata.ste_joy.word) |
			({WORD_W{io_sel.ste_snd}}    & io_rdata.ste_snd.word) |
			({WORD_W{io_sel.vme}}        & io_rdata.vme.word) |
			{hi_lane, lo_lane};
	end

	assign cpu_rdata = cpu2mem ? ram_word : io_word;

	// no dtack on rom writes or unmapped io, and none while a master holds the bus
	assign dtack = ((cpu2mem && cpu_cycle && cpu.as) || (|io_sel) || auto_iack) && !br;

endmodule

/* hdl/st_bus_pkg.sv */
/*
 * ST bus glue shared definitions
 * bus widths, memory and io map constants, the configuration word,
 * CPU and RAM bus structs, io selects and the io data union
 */
package st_bus_pkg;

	// widths fixed by the ST bus and the 64 bit SDRAM read
	localparam int WORD_W  = 16;
	localparam int LINE_W  = 64;
	localparam int WADDR_W = 23;

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [LINE_W-1:0]  line_t;
	typedef logic [WADDR_W-1:0] waddr_t;

	// mem_size encodings that open RAM above 4M
	localparam logic [2:0] MEM_8M  = 3'd4;
	localparam logic [2:0] MEM_14M = 3'd5;

	// address pages, compared against byte address bits 23..16
	localparam logic [7:0] CART_PAGE   = 8'hfa;
	localparam logic [7:0] DONGLE_PAGE = 8'hfb;
	localparam logic [7:0] TOS192_HI   = 8'hfe;
	localparam logic [7:0] IO_PAGE     = 8'hff;
	// wider rom and ram areas, compared against the top bits only
	localparam logic [5:0] TOS256_AREA   = 6'b111000;
	localparam logic [6:0] TOS192_LO     = 7'b1111110;
	localparam logic [4:0] STEROIDS_AREA = 5'b11101;

	// io window base offsets inside the $ff page
	localparam logic [15:0] IO_MMU       = 16'h8000;
	localparam logic [15:0] IO_VREG      = 16'h8200;
	localparam logic [15:0] IO_DMA       = 16'h8600;
	localparam logic [15:0] IO_PSG       = 16'h8800;
	localparam logic [15:0] IO_STE_SND   = 16'h8900;
	localparam logic [15:0] IO_BLITTER   = 16'h8a00;
	localparam logic [15:0] IO_VME       = 16'h8e00;
	localparam logic [15:0] IO_MSTE_CTRL = 16'h8e20;
	localparam logic [15:0] IO_STE_JOY   = 16'h9200;
	localparam logic [15:0] IO_MFP       = 16'hfa00;
	localparam logic [15:0] IO_ACIA      = 16'hfc00;

	// interrupt acknowledge: function code and level on address bits 3..1
	localparam logic [2:0] FC_IACK  = 3'b111;
	localparam logic [2:0] IACK_MFP = 3'b110;
	localparam logic [2:0] IACK_VBI = 3'b100;
	localparam logic [2:0] IACK_HBI = 3'b010;

	// ipl is active low, bit 0 is tied high on the ST
	localparam logic [2:0] IPL_MFP  = 3'b001;
	localparam logic [2:0] IPL_VBI  = 3'b011;
	localparam logic [2:0] IPL_HBI  = 3'b101;
	localparam logic [2:0] IPL_NONE = 3'b111;

	localparam logic [7:0] VEC_VBI = 8'h1c;
	localparam logic [7:0] VEC_HBI = 8'h1a;

	localparam logic [3:0] BERR_LIMIT = 4'd15;

	typedef struct packed {
		logic [2:0] mem_size;
		logic       ste;
		logic       mste;
		logic       blitter_en;
		logic       dongle_present;
		logic       enable_16mhz;
	} st_cfg_t;

	// strobes here are active high
	typedef struct packed {
		waddr_t     adr;
		logic [2:0] fc;
		logic       as;
		logic       rw;
		logic       uds;
		logic       lds;
		word_t      dout;
	} cpu_bus_t;

	typedef struct packed {
		logic   br;
		waddr_t addr;
		logic   read;
		logic   write;
		word_t  dout;
	} master_req_t;

	typedef struct packed {
		waddr_t addr;
		logic   oe;
		logic   wr;
		logic   uds;
		logic   lds;
		word_t  din;
	} ram_req_t;

	typedef struct packed {
		logic vreg;
		logic mmu;
		logic mste_ctrl;
		logic vme;
		logic ste_joy;
		logic ste_snd;
		logic mfp;
		logic acia;
		logic blitter;
		logic psg;
		logic dma;
		logic dongle;
		logic mfp_iack;
	} io_sel_t;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} io_lanes_t;

	// 16 bit devices are read as word, byte wide ones on their own lane
	typedef union packed {
		word_t     word;
		io_lanes_t lanes;
	} io_data_t;

	typedef struct packed {
		io_data_t vreg;
		io_data_t mmu;
		io_data_t mste_ctrl;
		io_data_t vme;
		io_data_t ste_joy;
		io_data_t ste_snd;
		io_data_t mfp;
		io_data_t acia;
		io_data_t blitter;
		io_data_t psg;
		io_data_t dma;
		io_data_t dongle;
		io_data_t mfp_iack;
	} io_rdata_t;

endpackage
